// ==== x87_exec.f ====
hdl/x87_pkg.sv
hdl/x87_reg_stack.sv
hdl/x87_status_unit.sv
hdl/x87_cmd_ctrl.sv
hdl/x87_exec.sv
testbench/x87_checker.sv
testbench/tb_x87_exec.sv

// ==== Bender.yml ====
package:
  name: x87_exec

sources:
  - hdl/x87_pkg.sv
  - hdl/x87_reg_stack.sv
  - hdl/x87_status_unit.sv
  - hdl/x87_cmd_ctrl.sv
  - hdl/x87_exec.sv
  - target: test
    files:
      - testbench/x87_checker.sv
      - testbench/tb_x87_exec.sv

// ==== testbench/tb_x87_exec.sv ====
`timescale 1ns/1ps

module tb_x87_exec import x87_pkg::*; ();

    localparam logic [15:0] FCW_RESET = 16'h037F;

    // Upper bounds, a random FSTP m64 counts twice
    localparam int DIRECTED_CMDS  = 96;
    localparam int RANDOM_CMDS    = 400;
    localparam int MAX_CMDS       = DIRECTED_CMDS + 2 * RANDOM_CMDS;
    localparam int TIMEOUT_CYCLES = 2 * MAX_CMDS + 100;

    logic        clk;
    logic        rst;
    logic        start;
    logic        cmd_valid;
    cmd_e        cmd;
    logic [2:0]  idx;
    logic [3:0]  step;
    logic [63:0] mem_rdata64;
    logic        done;
    wb_t         wb;
    mem_store_t  mem_store;

    int          cycles = 0;
    int          test_start_errs = 0;
    logic [63:0] class_vals [6];

    x87_exec #(
        .FCW_RESET (FCW_RESET)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .idx         (idx),
        .step        (step),
        .mem_rdata64 (mem_rdata64),
        .done        (done),
        .wb          (wb),
        .mem_store   (mem_store)
    );

    x87_checker #(
        .FCW_RESET (FCW_RESET)
    ) u_checker (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .idx         (idx),
        .step        (step),
        .mem_rdata64 (mem_rdata64),
        .done        (done),
        .wb          (wb),
        .mem_store   (mem_store)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run timed out after %0d cycles without finishing", cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // ----------------------------------------------------------
    // Stimulus helpers
    // ----------------------------------------------------------

    task automatic issue(cmd_e c, logic [2:0] i, logic [3:0] s, logic [63:0] d);
        @(posedge clk);
        start       <= 1'b1;
        cmd_valid   <= 1'b1;
        cmd         <= c;
        idx         <= i;
        step        <= s;
        mem_rdata64 <= d;
    endtask

    task automatic store_pop();
        issue(CMD_FSTP_M64, 3'd0, 4'd0, '0);
        issue(CMD_FSTP_M64, 3'd0, 4'd1, '0);
    endtask

    // Drain the last command, then report
    task automatic end_test(string name);
        @(posedge clk);
        start     <= 1'b0;
        cmd_valid <= 1'b0;
        do @(posedge clk); while (!done);
        #1;
        $display("Test %s finished with %0d mismatches", name,
                 u_checker.error_count - test_start_errs);
        test_start_errs = u_checker.error_count;
    endtask

    // Zeros, infinities, NaNs and denormals mixed with normals
    function automatic logic [63:0] random_operand();
        logic        sign;
        logic [51:0] frac;
        sign = 1'($urandom_range(0, 1));
        frac = {20'($urandom), $urandom};
        case ($urandom_range(0, 7))
            0: return {sign, 63'd0};
            1: return {sign, 11'h7FF, 52'd0};
            2: return {sign, 11'h7FF, frac | 52'd1};
            3: return {sign, 11'h000, frac | 52'd1};
            default: return {sign, 11'($urandom_range(1, 2046)), frac};
        endcase
    endfunction

    task automatic random_command();
        logic [63:0] d;
        logic [2:0]  i;
        d = random_operand();
        i = 3'($urandom_range(0, 7));
        case ($urandom_range(0, 15))
            0: issue(CMD_FNSTSW_AX, i, 4'd0, d);
            1: issue(CMD_FNINIT, i, 4'd0, d);
            2: issue(CMD_FLDCW, i, 4'd0, d);
            3: issue(CMD_FNSTCW, i, 4'd0, d);
            4: issue(CMD_FWAIT, i, 4'd0, d);
            5: issue(cmd_e'(5'd20), i, 4'd0, d);
            6, 7: issue(CMD_FLD_M64, i, 4'd0, d);
            8, 9: store_pop();
            10: issue(CMD_FLD_STI, i, 4'd0, d);
            11: issue(CMD_FXCH_STI, i, 4'd0, d);
            12: issue(CMD_FSTP_STI, i, 4'd0, d);
            default: issue(CMD_MISC, i, 4'd0, d);
        endcase
    endtask

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------

    initial begin
        rst         = 1'b1;
        start       = 1'b0;
        cmd_valid   = 1'b0;
        cmd         = CMD_NOP;
        idx         = '0;
        step        = '0;
        mem_rdata64 = '0;
        void'($urandom(49313));
        class_vals[0] = 64'h0000_0000_0000_0000;
        class_vals[1] = 64'hFFF0_0000_0000_0000;
        class_vals[2] = 64'h7FF8_0000_0000_0001;
        class_vals[3] = 64'h8000_0000_0000_1234;
        class_vals[4] = 64'hC000_0000_0000_0000;
        class_vals[5] = 64'h4009_21FB_5444_2D18;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        issue(CMD_FNSTSW_AX, 3'd0, 4'd0, '0);
        issue(CMD_FNSTCW, 3'd0, 4'd0, '0);
        end_test("after_reset");

        issue(CMD_FLD_M64, 3'd0, 4'd0, 64'h3FF0_0000_0000_0000);
        issue(CMD_FLD_M64, 3'd0, 4'd0, 64'hC000_0000_0000_0000);
        issue(CMD_FLD_M64, 3'd0, 4'd0, 64'h4009_21FB_5444_2D18);
        repeat (3) store_pop();
        end_test("load_store");

        // Eight pushes wrap TOP back to slot 0
        issue(CMD_FNINIT, 3'd0, 4'd0, '0);
        for (int k = 0; k < 8; k++) begin
            issue(CMD_FLD_M64, 3'd0, 4'd0, 64'h4000_0000_0000_0000 + k);
        end
        issue(CMD_FLD_STI, 3'd3, 4'd0, '0);
        issue(CMD_FXCH_STI, 3'd2, 4'd0, '0);
        issue(CMD_FSTP_STI, 3'd1, 4'd0, '0);
        repeat (4) store_pop();
        end_test("register_moves");

        issue(CMD_FLD_M64, 3'd0, 4'd0, 64'h3FF0_0000_0000_0000);
        issue(CMD_MISC, MISC_FCHS, 4'd0, '0);
        store_pop();
        issue(CMD_FLD_M64, 3'd0, 4'd0, 64'hC000_0000_0000_0000);
        issue(CMD_MISC, MISC_FABS, 4'd0, '0);
        store_pop();
        end_test("sign_ops");

        for (int k = 0; k < 6; k++) begin
            issue(CMD_FLD_M64, 3'd0, 4'd0, class_vals[k]);
            issue(CMD_MISC, MISC_FTST, 4'd0, '0);
            issue(CMD_FNSTSW_AX, 3'd0, 4'd0, '0);
            issue(CMD_MISC, MISC_FXAM, 4'd0, '0);
            issue(CMD_FNSTSW_AX, 3'd0, 4'd0, '0);
            store_pop();
        end
        issue(CMD_FNINIT, 3'd0, 4'd0, '0);
        issue(CMD_MISC, MISC_FXAM, 4'd0, '0);
        issue(CMD_FNSTSW_AX, 3'd0, 4'd0, '0);
        // FCHS on an empty ST0 must not touch the entry
        issue(CMD_MISC, MISC_FCHS, 4'd0, '0);
        store_pop();
        end_test("classify");

        issue(CMD_FLDCW, 3'd0, 4'd0, 64'h0000_0000_0000_0C7F);
        issue(CMD_FNSTCW, 3'd0, 4'd0, '0);
        issue(CMD_FNINIT, 3'd0, 4'd0, '0);
        issue(CMD_FNSTCW, 3'd0, 4'd0, '0);
        issue(CMD_FNSTSW_AX, 3'd0, 4'd0, '0);
        issue(CMD_FLD_M64, 3'd0, 4'd0, 64'h4010_0000_0000_0000);
        issue(CMD_FSTP_M64, 3'd0, 4'd0, '0);
        issue(CMD_FNINIT, 3'd0, 4'd0, '0);
        issue(CMD_FSTP_M64, 3'd0, 4'd1, '0);
        end_test("control_word_init");

        for (int n = 0; n < RANDOM_CMDS; n++) begin
            random_command();
        end
        end_test("random");

        $display("Checks: %0d, mismatches: %0d", u_checker.check_count,
                 u_checker.error_count);
        if (u_checker.error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/x87_checker.sv ====
`timescale 1ns/1ps

module x87_checker import x87_pkg::*; #(
    parameter logic [15:0] FCW_RESET = 16'h037F
) (
    input logic        clk,
    input logic        rst,
    input logic        start,
    input logic        cmd_valid,
    input cmd_e        cmd,
    input logic [2:0]  idx,
    input logic [3:0]  step,
    input logic [63:0] mem_rdata64,
    input logic        done,
    input wb_t         wb,
    input mem_store_t  mem_store
);

    typedef struct packed {
        logic       done;
        wb_t        wb;
        mem_store_t mem_store;
    } result_t;

    // Model state, indexed by physical slot
    logic [63:0] m_reg [8];
    logic [1:0]  m_tag [8];
    logic [2:0]  m_top;
    logic [15:0] m_fcw;
    logic [15:0] m_fsw;
    logic [63:0] m_latch;
    logic        m_latch_valid;

    result_t expected;
    result_t want;
    logic    pending;
    int      error_count = 0;
    int      check_count = 0;

    // Condition codes C3, C2, C0
    function automatic void set_cc(logic [2:0] cc);
        m_fsw[FSW_C3] = cc[2];
        m_fsw[FSW_C2] = cc[1];
        m_fsw[FSW_C0] = cc[0];
    endfunction

    // ----------------------------------------------------------
    // Reference model, one command at a time
    // ----------------------------------------------------------

    function automatic result_t apply_cmd(cmd_e c, logic [2:0] i, logic [3:0] s,
                                          logic [63:0] d);
        result_t     r;
        logic [63:0] v;
        logic [1:0]  t;
        logic [2:0]  p;
        logic        is_nan;
        logic        is_inf;
        logic        is_zero;
        logic        is_den;
        r       = '0;
        r.done  = 1'b1;
        v       = m_reg[m_top];
        p       = m_top + i;
        is_nan  = (v[62:52] == 11'h7FF) && (v[51:0] != '0);
        is_inf  = (v[62:52] == 11'h7FF) && (v[51:0] == '0);
        is_zero = (v[62:0] == '0);
        is_den  = (v[62:52] == 11'h000) && (v[51:0] != '0);
        case (c)
            CMD_FNSTSW_AX: r.wb = '{1'b1, WB_AX, m_fsw};
            CMD_FNINIT: begin
                for (int k = 0; k < 8; k++) begin
                    m_tag[k] = TAG_EMPTY;
                end
                m_top         = '0;
                m_fcw         = FCW_RESET;
                m_fsw         = '0;
                m_latch_valid = 1'b0;
            end
            CMD_FLDCW: m_fcw = d[15:0];
            CMD_FNSTCW: r.mem_store = '{1'b1, 2'd0, {48'd0, m_fcw}};
            CMD_FLD_M64: begin
                m_top        = m_top - 3'd1;
                m_reg[m_top] = d;
                m_tag[m_top] = TAG_VALID;
            end
            CMD_FSTP_M64: begin
                if (!s[0]) begin
                    r.mem_store   = '{1'b1, 2'd2, v};
                    m_latch       = v;
                    m_latch_valid = 1'b1;
                end else begin
                    r.mem_store   = '{m_latch_valid, 2'd2, m_latch};
                    m_latch_valid = 1'b0;
                    m_tag[m_top]  = TAG_EMPTY;
                    m_top         = m_top + 3'd1;
                end
            end
            CMD_FLD_STI: begin
                // Source read before TOP moves
                t            = m_tag[p];
                v            = m_reg[p];
                m_top        = m_top - 3'd1;
                m_reg[m_top] = v;
                m_tag[m_top] = t;
            end
            CMD_FXCH_STI: begin
                m_reg[m_top] = m_reg[p];
                m_reg[p]     = v;
            end
            CMD_FSTP_STI: begin
                m_reg[p]     = v;
                m_tag[p]     = m_tag[m_top];
                m_tag[m_top] = TAG_EMPTY;
                m_top        = m_top + 3'd1;
            end
            CMD_MISC: begin
                if (m_tag[m_top] == TAG_EMPTY) begin
                    m_fsw[FSW_IE] = 1'b1;
                    set_cc(3'b111);
                end else begin
                    case (i)
                        MISC_FCHS: m_reg[m_top] = {~v[63], v[62:0]};
                        MISC_FABS: m_reg[m_top] = {1'b0, v[62:0]};
                        MISC_FTST: begin
                            if (is_nan) begin
                                m_fsw[FSW_IE] = 1'b1;
                                set_cc(3'b111);
                            end else if (is_zero) begin
                                set_cc(3'b100);
                            end else begin
                                set_cc({2'b00, v[63]});
                            end
                        end
                        MISC_FXAM: begin
                            m_fsw[FSW_C1] = v[63];
                            if (is_nan) set_cc(3'b111);
                            else if (is_inf) set_cc(3'b011);
                            else if (is_zero) set_cc(3'b100);
                            else if (is_den) set_cc(3'b110);
                            else set_cc(3'b010);
                        end
                        default: begin
                        end
                    endcase
                end
            end
            default: begin
            end
        endcase
        return r;
    endfunction

    task automatic check_value(string name, logic [63:0] exp_v, logic [63:0] got_v);
        check_count++;
        if (exp_v !== got_v) begin
            error_count++;
            $display("ERR t=%0t %s exp=%h got=%h", $time, name, exp_v, got_v);
        end
    endtask

    // ----------------------------------------------------------
    // Compare one cycle after each accepted command
    // ----------------------------------------------------------

    always @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < 8; k++) begin
                m_reg[k] = '0;
                m_tag[k] = TAG_EMPTY;
            end
            m_top         = '0;
            m_fcw         = FCW_RESET;
            m_fsw         = '0;
            m_latch       = '0;
            m_latch_valid = 1'b0;
            expected      = '0;
            pending       = 1'b0;
        end else begin
            // Idle cycles expect all outputs low
            want = pending ? expected : '0;
            check_value("done", want.done, done);
            check_value("wb.valid", want.wb.valid, wb.valid);
            if (want.wb.valid) begin
                check_value("wb.kind", want.wb.kind, wb.kind);
                check_value("wb.value", want.wb.value, wb.value);
            end
            check_value("mem_store.valid", want.mem_store.valid, mem_store.valid);
            if (want.mem_store.valid) begin
                check_value("mem_store.size", want.mem_store.size, mem_store.size);
                check_value("mem_store.data", want.mem_store.data, mem_store.data);
            end
            pending = start && cmd_valid;
            if (pending) begin
                expected = apply_cmd(cmd, idx, step, mem_rdata64);
            end
        end
    end

endmodule

// ==== hdl/x87_exec.sv ====
`timescale 1ns/1ps

module x87_exec import x87_pkg::*; #(
    parameter logic [15:0] FCW_RESET = 16'h037F
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic        cmd_valid,
    input  cmd_e        cmd,
    input  logic [2:0]  idx,
    input  logic [3:0]  step,
    input  logic [63:0] mem_rdata64,
    output logic        done,
    output wb_t         wb,
    output mem_store_t  mem_store
);

    stack_req_t  stack_req;
    status_req_t status_req;
    logic [63:0] st0;
    logic [1:0]  st0_tag;
    logic [1:0]  sti_tag;
    logic [15:0] fcw;
    logic [15:0] fsw;

    // Decode and registered outputs
    x87_cmd_ctrl u_cmd_ctrl (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .idx         (idx),
        .step        (step),
        .mem_rdata64 (mem_rdata64),
        .st0         (st0),
        .st0_tag     (st0_tag),
        .sti_tag     (sti_tag),
        .fsw         (fsw),
        .fcw         (fcw),
        .stack_req   (stack_req),
        .status_req  (status_req),
        .done        (done),
        .wb          (wb),
        .mem_store   (mem_store)
    );

    x87_reg_stack u_reg_stack (
        .clk     (clk),
        .rst     (rst),
        .req     (stack_req),
        .st0     (st0),
        .st0_tag (st0_tag),
        .sti_tag (sti_tag)
    );

    x87_status_unit #(
        .FCW_RESET (FCW_RESET)
    ) u_status_unit (
        .clk (clk),
        .rst (rst),
        .req (status_req),
        .st0 (st0),
        .fcw (fcw),
        .fsw (fsw)
    );

endmodule

// ==== hdl/x87_cmd_ctrl.sv ====
`timescale 1ns/1ps

module x87_cmd_ctrl import x87_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic        cmd_valid,
    input  cmd_e        cmd,
    input  logic [2:0]  idx,
    input  logic [3:0]  step,
    input  logic [63:0] mem_rdata64,
    input  logic [63:0] st0,
    input  logic [1:0]  st0_tag,
    input  logic [1:0]  sti_tag,
    input  logic [15:0] fsw,
    input  logic [15:0] fcw,
    output stack_req_t  stack_req,
    output status_req_t status_req,
    output logic        done,
    output wb_t         wb,
    output mem_store_t  mem_store
);

    logic       accept;
    logic       st0_empty;
    misc_op_e   misc_op;
    wb_t        wb_next;
    mem_store_t mem_store_next;
    logic       latch_load;
    logic       latch_clear;

    // Holds ST0 between the two FSTP m64 steps
    logic [63:0] store_latch;
    logic        store_latch_valid;

    assign accept    = start && cmd_valid;
    assign st0_empty = (st0_tag == TAG_EMPTY);
    assign misc_op   = misc_op_e'(idx);

    // ----------------------------------------------------------
    // Command decode
    // ----------------------------------------------------------

    always_comb begin
        stack_req      = '{op: STK_NONE, idx: idx, data: '0};
        status_req     = '{op: STS_NONE, cw: '0};
        wb_next        = '{valid: 1'b0, kind: WB_NONE, value: '0};
        mem_store_next = '{valid: 1'b0, size: MS_SIZE_16, data: '0};
        latch_load     = 1'b0;
        latch_clear    = 1'b0;
        if (accept) begin
            case (cmd)
                CMD_FNSTSW_AX: wb_next = '{valid: 1'b1, kind: WB_AX, value: fsw};
                CMD_FNINIT: begin
                    stack_req.op  = STK_INIT;
                    status_req.op = STS_INIT;
                    latch_clear   = 1'b1;
                end
                CMD_FLDCW: status_req = '{op: STS_LOAD_CW, cw: mem_rdata64[15:0]};
                CMD_FNSTCW: begin
                    mem_store_next = '{valid: 1'b1, size: MS_SIZE_16, data: {48'd0, fcw}};
                end
                CMD_FLD_M64: begin
                    stack_req.op   = STK_PUSH_VALUE;
                    stack_req.data = mem_rdata64;
                end
                CMD_FSTP_M64: begin
                    if (!step[0]) begin
                        mem_store_next = '{valid: 1'b1, size: MS_SIZE_64, data: st0};
                        latch_load     = 1'b1;
                    end else begin
                        // Second step pops and replays the latched value
                        mem_store_next = '{valid: store_latch_valid, size: MS_SIZE_64,
                                           data: store_latch};
                        stack_req.op   = STK_POP;
                        latch_clear    = 1'b1;
                    end
                end
                CMD_FLD_STI: begin
                    stack_req.op   = STK_PUSH_COPY;
                    stack_req.data = {62'd0, sti_tag};
                end
                CMD_FXCH_STI: stack_req.op = STK_EXCHANGE;
                CMD_FSTP_STI: stack_req.op = STK_MOVE_POP;
                CMD_MISC: begin
                    if (st0_empty) begin
                        status_req.op = STS_STACK_FAULT;
                    end else begin
                        case (misc_op)
                            MISC_FCHS: stack_req = '{op: STK_SET_ST0, idx: idx,
                                                     data: {~st0[63], st0[62:0]}};
                            MISC_FABS: stack_req = '{op: STK_SET_ST0, idx: idx,
                                                     data: {1'b0, st0[62:0]}};
                            MISC_FTST: status_req.op = STS_TEST;
                            MISC_FXAM: status_req.op = STS_EXAMINE;
                            default: begin
                            end
                        endcase
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // ----------------------------------------------------------
    // Registered outputs and store latch
    // ----------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            done              <= 1'b0;
            wb                <= '0;
            mem_store         <= '0;
            store_latch_valid <= 1'b0;
        end else begin
            done      <= accept;
            wb        <= wb_next;
            mem_store <= mem_store_next;
            if (latch_load) begin
                store_latch_valid <= 1'b1;
            end else if (latch_clear) begin
                store_latch_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (latch_load) begin
            store_latch <= st0;
        end
    end

endmodule

// ==== hdl/x87_status_unit.sv ====
`timescale 1ns/1ps

module x87_status_unit import x87_pkg::*; #(
    parameter logic [15:0] FCW_RESET = 16'h037F
) (
    input  logic        clk,
    input  logic        rst,
    input  status_req_t req,
    input  logic [63:0] st0,
    output logic [15:0] fcw,
    output logic [15:0] fsw
);

    logic        sign;
    logic [10:0] expo;
    logic [51:0] frac;
    fp_class_e   st0_class;

    assign sign = st0[63];
    assign expo = st0[62:52];
    assign frac = st0[51:0];

    // ----------------------------------------------------------
    // Operand classifier for FTST and FXAM
    // ----------------------------------------------------------

    always_comb begin
        if (expo == 11'h7FF) begin
            st0_class = (frac != '0) ? CLS_NAN : CLS_INF;
        end else if (expo == 11'h000) begin
            st0_class = (frac != '0) ? CLS_DENORMAL : CLS_ZERO;
        end else begin
            st0_class = CLS_NORMAL;
        end
    end

    // ----------------------------------------------------------
    // Control and status word registers
    // ----------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            fcw <= FCW_RESET;
            fsw <= FSW_RESET;
        end else begin
            case (req.op)
                STS_INIT: begin
                    fcw <= FCW_RESET;
                    fsw <= FSW_RESET;
                end
                STS_LOAD_CW: begin
                    fcw <= req.cw;
                end
                STS_STACK_FAULT: begin
                    fsw[FSW_IE] <= 1'b1;
                    fsw[FSW_C0] <= 1'b1;
                    fsw[FSW_C2] <= 1'b1;
                    fsw[FSW_C3] <= 1'b1;
                end
                STS_TEST: begin
                    // Compare against +0, NaN is unordered and invalid
                    if (st0_class == CLS_NAN) begin
                        fsw[FSW_IE] <= 1'b1;
                        {fsw[FSW_C3], fsw[FSW_C2], fsw[FSW_C0]} <= 3'b111;
                    end else if (st0_class == CLS_ZERO) begin
                        {fsw[FSW_C3], fsw[FSW_C2], fsw[FSW_C0]} <= 3'b100;
                    end else begin
                        {fsw[FSW_C3], fsw[FSW_C2], fsw[FSW_C0]} <= {2'b00, sign};
                    end
                end
                STS_EXAMINE: begin
                    fsw[FSW_C1] <= sign;
                    case (st0_class)
                        CLS_NAN:      {fsw[FSW_C3], fsw[FSW_C2], fsw[FSW_C0]} <= 3'b111;
                        CLS_INF:      {fsw[FSW_C3], fsw[FSW_C2], fsw[FSW_C0]} <= 3'b011;
                        CLS_ZERO:     {fsw[FSW_C3], fsw[FSW_C2], fsw[FSW_C0]} <= 3'b100;
                        CLS_DENORMAL: {fsw[FSW_C3], fsw[FSW_C2], fsw[FSW_C0]} <= 3'b110;
                        default:      {fsw[FSW_C3], fsw[FSW_C2], fsw[FSW_C0]} <= 3'b010;
                    endcase
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== hdl/x87_reg_stack.sv ====
`timescale 1ns/1ps

module x87_reg_stack import x87_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  stack_req_t  req,
    output logic [63:0] st0,
    output logic [1:0]  st0_tag,
    output logic [1:0]  sti_tag
);

    logic [63:0] entry [8];
    logic [15:0] tag_word;
    logic [2:0]  top;

    // Physical slots of ST0, ST(idx) and the slot a push lands in
    logic [2:0] slot_st0;
    logic [2:0] slot_sti;
    logic [2:0] slot_push;

    assign slot_st0  = top;
    assign slot_sti  = top + req.idx;
    assign slot_push = top - 3'd1;

    assign st0     = entry[slot_st0];
    assign st0_tag = tag_word[{slot_st0, 1'b0} +: 2];
    assign sti_tag = tag_word[{slot_sti, 1'b0} +: 2];

    // ----------------------------------------------------------
    // Stack update
    // ----------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                entry[i] <= '0;
            end
            tag_word <= {8{TAG_EMPTY}};
            top      <= '0;
        end else begin
            case (req.op)
                STK_INIT: begin
                    // Entries keep their contents
                    tag_word <= {8{TAG_EMPTY}};
                    top      <= '0;
                end
                STK_PUSH_VALUE: begin
                    entry[slot_push]                   <= req.data;
                    tag_word[{slot_push, 1'b0} +: 2] <= TAG_VALID;
                    top                                <= slot_push;
                end
                STK_PUSH_COPY: begin
                    // Tag of the source entry comes in the low data bits
                    entry[slot_push]                   <= entry[slot_sti];
                    tag_word[{slot_push, 1'b0} +: 2] <= req.data[1:0];
                    top                                <= slot_push;
                end
                STK_EXCHANGE: begin
                    entry[slot_st0] <= entry[slot_sti];
                    entry[slot_sti] <= entry[slot_st0];
                end
                STK_MOVE_POP: begin
                    // With idx 0 the empty mark wins
                    entry[slot_sti]                   <= entry[slot_st0];
                    tag_word[{slot_sti, 1'b0} +: 2] <= tag_word[{slot_st0, 1'b0} +: 2];
                    tag_word[{slot_st0, 1'b0} +: 2] <= TAG_EMPTY;
                    top                               <= top + 3'd1;
                end
                STK_POP: begin
                    tag_word[{slot_st0, 1'b0} +: 2] <= TAG_EMPTY;
                    top                               <= top + 3'd1;
                end
                STK_SET_ST0: begin
                    entry[slot_st0] <= req.data;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== hdl/x87_pkg.sv ====
package x87_pkg;

    // ----------------------------------------------------------
    // Command and operation encodings
    // ----------------------------------------------------------

    // Command codes as seen on the cmd input, unlisted codes act as NOP
    typedef enum logic [4:0] {
        CMD_NOP       = 5'd0,
        CMD_FNSTSW_AX = 5'd1,
        CMD_FNINIT    = 5'd2,
        CMD_FLDCW     = 5'd3,
        CMD_FNSTCW    = 5'd4,
        CMD_FWAIT     = 5'd5,
        CMD_FLD_M64   = 5'd7,
        CMD_FSTP_M64  = 5'd9,
        CMD_FLD_STI   = 5'd10,
        CMD_FXCH_STI  = 5'd11,
        CMD_FSTP_STI  = 5'd12,
        CMD_MISC      = 5'd31
    } cmd_e;

    // Misc group selector, carried in idx
    typedef enum logic [2:0] {
        MISC_FCHS = 3'd0,
        MISC_FABS = 3'd1,
        MISC_FTST = 3'd2,
        MISC_FXAM = 3'd3
    } misc_op_e;

    typedef enum logic [2:0] {
        STK_NONE,
        STK_INIT,
        STK_PUSH_VALUE,
        STK_PUSH_COPY,
        STK_EXCHANGE,
        STK_MOVE_POP,
        STK_POP,
        STK_SET_ST0
    } stack_op_e;

    typedef enum logic [2:0] {
        STS_NONE,
        STS_INIT,
        STS_LOAD_CW,
        STS_STACK_FAULT,
        STS_TEST,
        STS_EXAMINE
    } status_op_e;

    typedef enum logic [2:0] {
        CLS_NAN,
        CLS_INF,
        CLS_ZERO,
        CLS_DENORMAL,
        CLS_NORMAL
    } fp_class_e;

    // ----------------------------------------------------------
    // Request and output bundles
    // ----------------------------------------------------------

    typedef struct packed {
        stack_op_e   op;
        logic [2:0]  idx;
        logic [63:0] data;
    } stack_req_t;

    typedef struct packed {
        status_op_e  op;
        logic [15:0] cw;
    } status_req_t;

    // Size 0 is a 16-bit store, size 2 a 64-bit store
    typedef struct packed {
        logic        valid;
        logic [1:0]  size;
        logic [63:0] data;
    } mem_store_t;

    typedef struct packed {
        logic        valid;
        logic [2:0]  kind;
        logic [15:0] value;
    } wb_t;

    localparam logic [2:0] WB_NONE = 3'd0;
    localparam logic [2:0] WB_AX   = 3'd1;

    localparam logic [1:0] MS_SIZE_16 = 2'd0;
    localparam logic [1:0] MS_SIZE_64 = 2'd2;

    // ----------------------------------------------------------
    // Tags and status word
    // ----------------------------------------------------------

    localparam logic [1:0]  TAG_VALID = 2'b00;
    localparam logic [1:0]  TAG_EMPTY = 2'b11;
    localparam logic [15:0] FSW_RESET = 16'h0000;

    localparam int unsigned FSW_IE = 0;
    localparam int unsigned FSW_C0 = 8;
    localparam int unsigned FSW_C1 = 9;
    localparam int unsigned FSW_C2 = 10;
    localparam int unsigned FSW_C3 = 14;

endpackage
